// ==== src/fads_pkg.sv ====
package fads_pkg;

    // sample, word and select widths
    localparam int ADC_W      = 14;
    localparam int WORD_W     = 32;
    localparam int N_CHAN_MAX = 6;
    localparam int SEL_W      = 3;
    localparam int CLASS_W    = 6;

    // class vector bits, same positions as the classification byte
    localparam int CLS_LOW_INT  = 0;
    localparam int CLS_POS_INT  = 1;
    localparam int CLS_HIGH_INT = 2;
    localparam int CLS_LOW_W    = 3;
    localparam int CLS_POS_W    = 4;
    localparam int CLS_HIGH_W   = 5;
    localparam int CLS_POSITIVE = 7;

    // cleared peak, most negative two's complement sample
    localparam logic signed [ADC_W-1:0] SAMPLE_MIN = {1'b1, {(ADC_W-1){1'b0}}};

    // reset defaults
    localparam logic signed [ADC_W-1:0] DEF_MIN_INT    = -14'sd250;
    localparam logic signed [ADC_W-1:0] DEF_LOW_INT    = -14'sd240;
    localparam logic signed [ADC_W-1:0] DEF_HIGH_INT   = 14'sd500;
    localparam logic [WORD_W-1:0]       DEF_MIN_W      = 32'd1;
    localparam logic [WORD_W-1:0]       DEF_LOW_W      = 32'd4;
    localparam logic [WORD_W-1:0]       DEF_HIGH_W     = 32'd64;
    localparam logic [WORD_W-1:0]       DEF_ENABLED    = 32'd0;
    localparam logic [SEL_W-1:0]        DEF_SENSE      = 3'd0;
    localparam logic [WORD_W-1:0]       DEF_SORT_DELAY = 32'd31250;
    localparam logic [WORD_W-1:0]       DEF_SORT_DUR   = 32'd125000;

    // register map, byte offsets inside the 20-bit decode window
    localparam logic [19:0] REG_CH_STRIDE  = 20'h00020;
    localparam logic [19:0] REG_MIN_INT    = 20'h00000;
    localparam logic [19:0] REG_LOW_INT    = 20'h00004;
    localparam logic [19:0] REG_HIGH_INT   = 20'h00008;
    localparam logic [19:0] REG_MIN_W      = 20'h00010;
    localparam logic [19:0] REG_LOW_W      = 20'h00014;
    localparam logic [19:0] REG_HIGH_W     = 20'h00018;
    localparam logic [19:0] REG_POS_CNT    = 20'h00100;
    localparam logic [19:0] REG_NEG_CNT    = 20'h00104;
    localparam logic [19:0] REG_DROPLET_ID = 20'h00108;
    localparam logic [19:0] REG_CLASS      = 20'h0010c;
    localparam logic [19:0] REG_ENABLED    = 20'h00300;
    localparam logic [19:0] REG_SENSE      = 20'h00304;
    localparam logic [19:0] REG_SORT_DELAY = 20'h00308;
    localparam logic [19:0] REG_SORT_DUR   = 20'h0030c;

    // bus word, raw or as a signed intensity threshold
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [WORD_W-ADC_W-1:0] pad;
            logic signed [ADC_W-1:0] intensity;
        } intens;
    } bus_word_u;

endpackage

// ==== src/fads_channel.sv ====
`timescale 1ns/10ps

module fads_channel import fads_pkg::*; #(
    parameter int CH_INDEX = 0
) (
    input  logic                    adc_clk_i,
    input  logic                    fads_reset,
    input  logic signed [ADC_W-1:0] adc_a_i,
    input  logic [SEL_W-1:0]        mux_addr_i,
    input  logic                    signal_stable_i,
    input  logic                    clear_i,
    input  logic                    acquire_i,
    input  logic signed [ADC_W-1:0] min_int_i,
    input  logic signed [ADC_W-1:0] low_int_i,
    input  logic signed [ADC_W-1:0] high_int_i,
    input  logic [WORD_W-1:0]       min_w_i,
    input  logic [WORD_W-1:0]       low_w_i,
    input  logic [WORD_W-1:0]       high_w_i,
    output logic                    above_min_o,
    output logic [CLASS_W-1:0]      cls_o
);

    logic                    own;
    logic                    w_ok;
    logic signed [ADC_W-1:0] peak;
    logic [WORD_W-1:0]       width;

    // settled sample from this channel's mux slot
    assign own         = signal_stable_i && (mux_addr_i == SEL_W'(CH_INDEX));
    assign above_min_o = own && (adc_a_i >= min_int_i);

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            peak  <= SAMPLE_MIN;
            width <= '0;
        end else if (clear_i) begin
            peak  <= above_min_o ? adc_a_i : SAMPLE_MIN;
            width <= above_min_o ? WORD_W'(1) : '0;
        end else if (acquire_i && own) begin
            if (adc_a_i > peak) begin
                peak <= adc_a_i;
            end
            // width counts own samples over the minimum
            if (above_min_o) begin
                width <= width + WORD_W'(1);
            end
        end
    end

    // intensity bands
    assign cls_o[CLS_LOW_INT]  = (peak >= min_int_i) && (peak < low_int_i);
    assign cls_o[CLS_POS_INT]  = (peak >= low_int_i) && (peak < high_int_i);
    assign cls_o[CLS_HIGH_INT] = (peak >= high_int_i);

    // width bands, all gated by min width
    assign w_ok                = (width >= min_w_i);
    assign cls_o[CLS_LOW_W]    = w_ok && (width < low_w_i);
    assign cls_o[CLS_POS_W]    = w_ok && (width >= low_w_i) && (width < high_w_i);
    assign cls_o[CLS_HIGH_W]   = w_ok && (width >= high_w_i);

endmodule

// ==== src/fads_regs.sv ====
`timescale 1ns/10ps

module fads_regs import fads_pkg::*; #(
    parameter int N_CHAN = N_CHAN_MAX
) (
    input  logic                    adc_clk_i,
    input  logic                    fads_reset,
    input  logic [31:0]             sys_addr_i,
    input  bus_word_u               sys_wdata_i,
    input  logic                    sys_wen_i,
    input  logic                    sys_ren_i,
    input  logic [WORD_W-1:0]       pos_cnt_i,
    input  logic [WORD_W-1:0]       neg_cnt_i,
    input  logic [WORD_W-1:0]       droplet_id_i,
    input  logic [7:0]              class_byte_i,
    output bus_word_u               sys_rdata_o,
    output logic                    sys_ack_o,
    output logic signed [ADC_W-1:0] min_int_o  [N_CHAN],
    output logic signed [ADC_W-1:0] low_int_o  [N_CHAN],
    output logic signed [ADC_W-1:0] high_int_o [N_CHAN],
    output logic [WORD_W-1:0]       min_w_o    [N_CHAN],
    output logic [WORD_W-1:0]       low_w_o    [N_CHAN],
    output logic [WORD_W-1:0]       high_w_o   [N_CHAN],
    output logic [N_CHAN-1:0]       enabled_o,
    output logic [SEL_W-1:0]        sense_addr_o,
    output logic [WORD_W-1:0]       sort_delay_o,
    output logic [WORD_W-1:0]       sort_duration_o
);

    logic [19:0]             addr;
    logic [19:0]             ch_idx;
    logic [19:0]             ch_off;
    logic                    ch_hit;
    logic [SEL_W-1:0]        ch;
    logic signed [ADC_W-1:0] rd_thr;
    bus_word_u               rd_word;

    // channel block index and offset inside the block
    assign addr   = sys_addr_i[19:0];
    assign ch_idx = addr / REG_CH_STRIDE;
    assign ch_off = addr % REG_CH_STRIDE;
    assign ch_hit = (ch_idx < N_CHAN);
    assign ch     = ch_idx[SEL_W-1:0];

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            for (int i = 0; i < N_CHAN; i++) begin
                min_int_o[i]  <= DEF_MIN_INT;
                low_int_o[i]  <= DEF_LOW_INT;
                high_int_o[i] <= DEF_HIGH_INT;
                min_w_o[i]    <= DEF_MIN_W;
                low_w_o[i]    <= DEF_LOW_W;
                high_w_o[i]   <= DEF_HIGH_W;
            end
            enabled_o       <= DEF_ENABLED[N_CHAN-1:0];
            sense_addr_o    <= DEF_SENSE;
            sort_delay_o    <= DEF_SORT_DELAY;
            sort_duration_o <= DEF_SORT_DUR;
        end else if (sys_wen_i) begin
            if (ch_hit) begin
                // intensity thresholds take the low ADC_W bits only
                case (ch_off)
                    REG_MIN_INT:  min_int_o[ch]  <= sys_wdata_i.intens.intensity;
                    REG_LOW_INT:  low_int_o[ch]  <= sys_wdata_i.intens.intensity;
                    REG_HIGH_INT: high_int_o[ch] <= sys_wdata_i.intens.intensity;
                    REG_MIN_W:    min_w_o[ch]    <= sys_wdata_i.raw;
                    REG_LOW_W:    low_w_o[ch]    <= sys_wdata_i.raw;
                    REG_HIGH_W:   high_w_o[ch]   <= sys_wdata_i.raw;
                    default: ;
                endcase
            end
            case (addr)
                REG_ENABLED:    enabled_o       <= sys_wdata_i.raw[N_CHAN-1:0];
                REG_SENSE:      sense_addr_o    <= sys_wdata_i.raw[SEL_W-1:0];
                REG_SORT_DELAY: sort_delay_o    <= sys_wdata_i.raw;
                REG_SORT_DUR:   sort_duration_o <= sys_wdata_i.raw;
                default: ;
            endcase
        end
    end

    // intensity threshold of the addressed channel
    always_comb begin
        case (ch_off)
            REG_LOW_INT:  rd_thr = low_int_o[ch];
            REG_HIGH_INT: rd_thr = high_int_o[ch];
            default:      rd_thr = min_int_o[ch];
        endcase
    end

    // read mux, unmapped words give 0
    always_comb begin
        rd_word.raw = '0;
        if (ch_hit) begin
            case (ch_off)
                REG_MIN_INT, REG_LOW_INT, REG_HIGH_INT: begin
                    // sign extended into the pad bits
                    rd_word.intens.pad       = {(WORD_W-ADC_W){rd_thr[ADC_W-1]}};
                    rd_word.intens.intensity = rd_thr;
                end
                REG_MIN_W:  rd_word.raw = min_w_o[ch];
                REG_LOW_W:  rd_word.raw = low_w_o[ch];
                REG_HIGH_W: rd_word.raw = high_w_o[ch];
                default: ;
            endcase
        end else begin
            case (addr)
                REG_POS_CNT:    rd_word.raw = pos_cnt_i;
                REG_NEG_CNT:    rd_word.raw = neg_cnt_i;
                REG_DROPLET_ID: rd_word.raw = droplet_id_i;
                REG_CLASS:      rd_word.raw = WORD_W'(class_byte_i);
                REG_ENABLED:    rd_word.raw = WORD_W'(enabled_o);
                REG_SENSE:      rd_word.raw = WORD_W'(sense_addr_o);
                REG_SORT_DELAY: rd_word.raw = sort_delay_o;
                REG_SORT_DUR:   rd_word.raw = sort_duration_o;
                default: ;
            endcase
        end
    end

    // one-cycle acknowledge for any strobe
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            sys_ack_o <= 1'b0;
        end else begin
            sys_ack_o <= sys_wen_i | sys_ren_i;
        end
    end

    // read data valid together with the acknowledge
    always_ff @(posedge adc_clk_i) begin
        if (sys_ren_i) begin
            sys_rdata_o <= rd_word;
        end
    end

endmodule

// ==== src/fads_sequencer.sv ====
`timescale 1ns/10ps

module fads_sequencer import fads_pkg::*; #(
    parameter int N_CHAN = N_CHAN_MAX
) (
    input  logic              adc_clk_i,
    input  logic              fads_reset,
    input  logic              signal_stable_i,
    input  logic [SEL_W-1:0]  mux_addr_i,
    input  logic [N_CHAN-1:0] above_min_i,
    input  logic              positive_i,
    input  logic [N_CHAN-1:0] enabled_i,
    input  logic [SEL_W-1:0]  sense_addr_i,
    input  logic [WORD_W-1:0] sort_delay_i,
    input  logic [WORD_W-1:0] sort_duration_i,
    output logic              clear_o,
    output logic              acquire_o,
    output logic              eval_o,
    output logic [N_CHAN-1:0] muxing_channels_o,
    output logic              sort_trig_o
);

    // state encoding
    localparam logic [2:0] S_WAIT    = 3'd0;
    localparam logic [2:0] S_ACQUIRE = 3'd1;
    localparam logic [2:0] S_EVAL    = 3'd2;
    localparam logic [2:0] S_DELAY   = 3'd3;
    localparam logic [2:0] S_SORT    = 3'd4;

    logic [2:0]        state;
    logic [WORD_W-1:0] cnt;
    logic [WORD_W-1:0] cnt_next;
    logic [N_CHAN-1:0] sense_hot;
    logic              sense_start;
    logic              sense_end;

    assign sense_hot = {{(N_CHAN-1){1'b0}}, 1'b1} << sense_addr_i;
    assign cnt_next  = cnt + WORD_W'(1);

    // droplet edge on the sensing channel
    assign sense_start = above_min_i[sense_addr_i];
    // first stable sensing sample under the minimum
    assign sense_end   = signal_stable_i && (mux_addr_i == sense_addr_i) &&
                         !above_min_i[sense_addr_i];

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state <= S_WAIT;
            cnt   <= '0;
        end else begin
            case (state)
                S_WAIT: begin
                    if (sense_start) begin
                        state <= S_ACQUIRE;
                    end
                end
                S_ACQUIRE: begin
                    if (sense_end) begin
                        state <= S_EVAL;
                    end
                end
                S_EVAL: begin
                    cnt <= '0;
                    // zero delay goes straight to the trigger
                    if (!positive_i) begin
                        state <= S_WAIT;
                    end else if (sort_delay_i == '0) begin
                        state <= S_SORT;
                    end else begin
                        state <= S_DELAY;
                    end
                end
                S_DELAY: begin
                    if (cnt_next >= sort_delay_i) begin
                        cnt   <= '0;
                        state <= S_SORT;
                    end else begin
                        cnt <= cnt_next;
                    end
                end
                S_SORT: begin
                    if (cnt_next >= sort_duration_i) begin
                        state <= S_WAIT;
                    end else begin
                        cnt <= cnt_next;
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    assign clear_o     = (state == S_WAIT) && sense_start;
    assign acquire_o   = (state == S_ACQUIRE);
    assign eval_o      = (state == S_EVAL);
    assign sort_trig_o = (state == S_SORT);

    // only the sensing channel is muxed while idle
    assign muxing_channels_o = (state == S_WAIT) ? sense_hot : (enabled_i | sense_hot);

endmodule

// ==== src/fads_verdict.sv ====
`timescale 1ns/10ps

module fads_verdict import fads_pkg::*; #(
    parameter int N_CHAN = N_CHAN_MAX
) (
    input  logic               adc_clk_i,
    input  logic               fads_reset,
    input  logic [CLASS_W-1:0] cls_i [N_CHAN],
    input  logic [N_CHAN-1:0]  active_i,
    input  logic               eval_i,
    output logic               positive_o,
    output logic [WORD_W-1:0]  pos_cnt_o,
    output logic [WORD_W-1:0]  neg_cnt_o,
    output logic [WORD_W-1:0]  droplet_id_o,
    output logic [7:0]         class_byte_o
);

    logic [N_CHAN-1:0]  ch_pos;
    logic [CLASS_W-1:0] cls_or;
    logic [7:0]         class_next;

    // per-channel in-band flags and OR of active channel classes
    always_comb begin
        cls_or = '0;
        for (int i = 0; i < N_CHAN; i++) begin
            ch_pos[i] = cls_i[i][CLS_POS_INT] & cls_i[i][CLS_POS_W];
            if (active_i[i]) begin
                cls_or = cls_or | cls_i[i];
            end
        end
    end

    // inactive channels do not veto
    assign positive_o = &(ch_pos | ~active_i);

    always_comb begin
        class_next               = 8'(cls_or);
        class_next[CLS_POSITIVE] = positive_o;
    end

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            pos_cnt_o    <= '0;
            neg_cnt_o    <= '0;
            droplet_id_o <= '0;
            class_byte_o <= '0;
        end else if (eval_i) begin
            droplet_id_o <= droplet_id_o + WORD_W'(1);
            class_byte_o <= class_next;
            // not positive means negative
            if (positive_o) begin
                pos_cnt_o <= pos_cnt_o + WORD_W'(1);
            end else begin
                neg_cnt_o <= neg_cnt_o + WORD_W'(1);
            end
        end
    end

endmodule

// ==== src/fads_top.sv ====
`timescale 1ns/10ps

module fads_top import fads_pkg::*; #(
    parameter int N_CHAN = N_CHAN_MAX
) (
    input  logic                    adc_clk_i,
    input  logic                    fads_reset,
    input  logic signed [ADC_W-1:0] adc_a_i,
    input  logic [SEL_W-1:0]        mux_addr_i,
    input  logic                    signal_stable_i,
    input  logic [31:0]             sys_addr_i,
    input  bus_word_u               sys_wdata_i,
    input  logic                    sys_wen_i,
    input  logic                    sys_ren_i,
    output bus_word_u               sys_rdata_o,
    output logic                    sys_ack_o,
    output logic                    sort_trig_o,
    output logic [N_CHAN-1:0]       muxing_channels_o
);

    // thresholds per channel
    logic signed [ADC_W-1:0] min_int  [N_CHAN];
    logic signed [ADC_W-1:0] low_int  [N_CHAN];
    logic signed [ADC_W-1:0] high_int [N_CHAN];
    logic [WORD_W-1:0]       min_w    [N_CHAN];
    logic [WORD_W-1:0]       low_w    [N_CHAN];
    logic [WORD_W-1:0]       high_w   [N_CHAN];

    // control words
    logic [N_CHAN-1:0]  enabled_channels;
    logic [SEL_W-1:0]   sense_addr;
    logic [WORD_W-1:0]  sort_delay;
    logic [WORD_W-1:0]  sort_duration;

    // sequencing and results
    logic               clear;
    logic               acquire;
    logic               eval;
    logic               positive;
    logic [N_CHAN-1:0]  above_min;
    logic [CLASS_W-1:0] cls [N_CHAN];
    logic [WORD_W-1:0]  pos_cnt;
    logic [WORD_W-1:0]  neg_cnt;
    logic [WORD_W-1:0]  droplet_id;
    logic [7:0]         class_byte;

    fads_regs #(.N_CHAN(N_CHAN)) u_regs (
        .adc_clk_i, .fads_reset, .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
        .pos_cnt_i(pos_cnt), .neg_cnt_i(neg_cnt), .droplet_id_i(droplet_id),
        .class_byte_i(class_byte), .sys_rdata_o, .sys_ack_o,
        .min_int_o(min_int), .low_int_o(low_int), .high_int_o(high_int),
        .min_w_o(min_w), .low_w_o(low_w), .high_w_o(high_w),
        .enabled_o(enabled_channels), .sense_addr_o(sense_addr),
        .sort_delay_o(sort_delay), .sort_duration_o(sort_duration)
    );

    fads_sequencer #(.N_CHAN(N_CHAN)) u_seq (
        .adc_clk_i, .fads_reset, .signal_stable_i, .mux_addr_i,
        .above_min_i(above_min), .positive_i(positive), .enabled_i(enabled_channels),
        .sense_addr_i(sense_addr), .sort_delay_i(sort_delay),
        .sort_duration_i(sort_duration), .clear_o(clear), .acquire_o(acquire),
        .eval_o(eval), .muxing_channels_o, .sort_trig_o
    );

    // one tracker per detector channel
    for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
        fads_channel #(.CH_INDEX(i)) u_chan (
            .adc_clk_i, .fads_reset, .adc_a_i, .mux_addr_i, .signal_stable_i,
            .clear_i(clear), .acquire_i(acquire),
            .min_int_i(min_int[i]), .low_int_i(low_int[i]), .high_int_i(high_int[i]),
            .min_w_i(min_w[i]), .low_w_i(low_w[i]), .high_w_i(high_w[i]),
            .above_min_o(above_min[i]), .cls_o(cls[i])
        );
    end

    fads_verdict #(.N_CHAN(N_CHAN)) u_verdict (
        .adc_clk_i, .fads_reset, .cls_i(cls), .active_i(muxing_channels_o),
        .eval_i(eval), .positive_o(positive), .pos_cnt_o(pos_cnt),
        .neg_cnt_o(neg_cnt), .droplet_id_o(droplet_id), .class_byte_o(class_byte)
    );

endmodule

// ==== tb/fads_tb.sv ====
`timescale 1ns/10ps

module fads_tb import fads_pkg::*; ();

    localparam int N_CHAN       = 6;
    localparam int N_ROWS       = 8;
    localparam int GAP          = 6;
    localparam int SORT_DELAY_T = 20;
    localparam int SORT_DUR_T   = 12;
    // upper bound on bus accesses in the whole run
    localparam int N_BUS        = 200;

    // one droplet: stimulus and expected results
    typedef struct packed {
        logic signed [ADC_W-1:0] peak0;
        logic signed [ADC_W-1:0] peak1;
        logic [7:0]              n;
        logic [N_CHAN-1:0]       en;
        logic                    pos;
        logic [WORD_W-1:0]       pos_cnt;
        logic [WORD_W-1:0]       neg_cnt;
        logic [7:0]              cls;
    } row_t;

    logic                    adc_clk_i;
    logic                    fads_reset;
    logic signed [ADC_W-1:0] adc_a_i;
    logic [SEL_W-1:0]        mux_addr_i;
    logic                    signal_stable_i;
    logic [31:0]             sys_addr_i;
    bus_word_u               sys_wdata_i;
    logic                    sys_wen_i;
    logic                    sys_ren_i;
    bus_word_u               sys_rdata_o;
    logic                    sys_ack_o;
    logic                    sort_trig_o;
    logic [N_CHAN-1:0]       muxing_channels_o;

    row_t        rows  [N_ROWS];
    string       names [N_ROWS];
    int          cycles;
    int          cycle_limit;
    int          seed_val;
    // threshold offsets inside a channel block, intensity first
    logic [19:0] thr_offs [6] = '{REG_MIN_INT, REG_LOW_INT, REG_HIGH_INT,
                                  REG_MIN_W, REG_LOW_W, REG_HIGH_W};

    fads_top #(.N_CHAN(N_CHAN)) DUT (
        .adc_clk_i, .fads_reset, .adc_a_i, .mux_addr_i, .signal_stable_i,
        .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i, .sys_rdata_o, .sys_ack_o,
        .sort_trig_o, .muxing_channels_o
    );

    initial begin
        adc_clk_i = 1'b0;
        forever #4 adc_clk_i = ~adc_clk_i;
    end

    // run limit guard
    always @(posedge adc_clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, run did not finish", cycles));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input bus_word_u exp, input bus_word_u act);
        if (act.raw !== exp.raw) begin
            stop_with_failure($sformatf("FAILED %s: expected %h, actual %h",
                                        name, exp.raw, act.raw));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input logic [N_CHAN-1:0] exp,
                              input logic [N_CHAN-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic logic [31:0] ch_addr(input int c, input logic [19:0] off);
        return 32'(c) * 32'(REG_CH_STRIDE) + 32'(off);
    endfunction

    // quiet sample, under every programmed minimum
    function automatic logic signed [ADC_W-1:0] baseline();
        return ADC_W'($urandom_range(99, 0)) - ADC_W'(50);
    endfunction

    // ack is a one-cycle pulse, seen on the first falling edge
    task automatic wait_ack(input logic [31:0] addr);
        int waited;
        waited = 0;
        @(negedge adc_clk_i);
        while (!sys_ack_o) begin
            waited++;
            if (waited > 4) begin
                stop_with_failure($sformatf("no bus acknowledge for address %h", addr));
            end
            @(negedge adc_clk_i);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        bus_word_u word;
        word.raw = data;
        @(posedge adc_clk_i);
        sys_addr_i  <= addr;
        sys_wdata_i <= word;
        sys_wen_i   <= 1'b1;
        @(posedge adc_clk_i);
        sys_wen_i <= 1'b0;
        wait_ack(addr);
    endtask

    task automatic read_reg(input logic [31:0] addr, output bus_word_u data);
        @(posedge adc_clk_i);
        sys_addr_i <= addr;
        sys_ren_i  <= 1'b1;
        @(posedge adc_clk_i);
        sys_ren_i <= 1'b0;
        wait_ack(addr);
        // read data valid alongside ack
        data = sys_rdata_o;
    endtask

    task automatic expect_reg(input string name, input logic [31:0] addr,
                              input logic [31:0] exp_raw);
        bus_word_u exp;
        bus_word_u got;
        exp.raw = exp_raw;
        read_reg(addr, got);
        check_word(name, exp, got);
    endtask

    // package defaults, intensity thresholds sign extended
    task automatic check_defaults(input string name);
        logic [31:0] defs [6];
        defs = '{int'(DEF_MIN_INT), int'(DEF_LOW_INT), int'(DEF_HIGH_INT),
                 DEF_MIN_W, DEF_LOW_W, DEF_HIGH_W};
        for (int c = 0; c < N_CHAN; c++) begin
            for (int i = 0; i < 6; i++) begin
                expect_reg(name, ch_addr(c, thr_offs[i]), defs[i]);
            end
        end
        expect_reg(name, 32'(REG_POS_CNT), 32'd0);
        expect_reg(name, 32'(REG_NEG_CNT), 32'd0);
        expect_reg(name, 32'(REG_DROPLET_ID), 32'd0);
        expect_reg(name, 32'(REG_CLASS), 32'd0);
        expect_reg(name, 32'(REG_ENABLED), DEF_ENABLED);
        expect_reg(name, 32'(REG_SENSE), 32'(DEF_SENSE));
        expect_reg(name, 32'(REG_SORT_DELAY), DEF_SORT_DELAY);
        expect_reg(name, 32'(REG_SORT_DUR), DEF_SORT_DUR);
    endtask

    task automatic check_readback();
        logic [31:0] ch0 [6];
        logic [31:0] ch5 [6];
        // droplet bands for channels 0 and 1, odd values for channel 5
        ch0 = '{32'd100, 32'd200, 32'd1000, 32'd2, 32'd4, 32'd10};
        ch5 = '{-32'sd1000, -32'sd300, 32'd2000, 32'd7, 32'd9, 32'd33};
        for (int i = 0; i < 6; i++) begin
            write_reg(ch_addr(0, thr_offs[i]), ch0[i]);
            write_reg(ch_addr(1, thr_offs[i]), ch0[i]);
            write_reg(ch_addr(5, thr_offs[i]), ch5[i]);
        end
        for (int i = 0; i < 6; i++) begin
            expect_reg("readback_ch0", ch_addr(0, thr_offs[i]), ch0[i]);
            expect_reg("readback_ch5", ch_addr(5, thr_offs[i]), ch5[i]);
        end
        write_reg(32'(REG_ENABLED), 32'h21);
        write_reg(32'(REG_SENSE), 32'd5);
        write_reg(32'(REG_SORT_DELAY), 32'(SORT_DELAY_T));
        write_reg(32'(REG_SORT_DUR), 32'(SORT_DUR_T));
        expect_reg("readback_ctrl", 32'(REG_ENABLED), 32'h21);
        expect_reg("readback_ctrl", 32'(REG_SENSE), 32'd5);
        expect_reg("readback_ctrl", 32'(REG_SORT_DELAY), 32'(SORT_DELAY_T));
        expect_reg("readback_ctrl", 32'(REG_SORT_DUR), 32'(SORT_DUR_T));
        // sensing back on channel 0 for the droplets
        write_reg(32'(REG_SENSE), 32'd0);
        // hole inside a block, channel 6 block, gaps in the map
        expect_reg("unmapped", ch_addr(0, 20'h0000c), 32'd0);
        expect_reg("unmapped", 32'h0000_00c0, 32'd0);
        expect_reg("unmapped", 32'h0000_0200, 32'd0);
        expect_reg("unmapped", 32'h0000_0400, 32'd0);
    endtask

    // gap, pulse on channel 0 (interleaved with channel 1 if enabled), end sample
    task automatic apply_droplet(input int r);
        logic dual;
        dual = (rows[r].en != '0);
        for (int k = 0; k < GAP; k++) begin
            @(posedge adc_clk_i);
            signal_stable_i <= 1'b1;
            mux_addr_i      <= '0;
            adc_a_i         <= baseline();
        end
        @(negedge adc_clk_i);
        check_mask(names[r], N_CHAN'(1), muxing_channels_o);
        for (int k = 0; k < rows[r].n; k++) begin
            @(posedge adc_clk_i);
            mux_addr_i <= '0;
            adc_a_i    <= rows[r].peak0;
            if (dual) begin
                @(posedge adc_clk_i);
                mux_addr_i <= SEL_W'(1);
                adc_a_i    <= rows[r].peak1;
            end
            // acquisition under way, enabled set plus sensing channel
            if (k == 1) begin
                @(negedge adc_clk_i);
                check_mask(names[r], rows[r].en | N_CHAN'(1), muxing_channels_o);
            end
        end
        @(posedge adc_clk_i);
        mux_addr_i <= '0;
        adc_a_i    <= baseline();
    endtask

    // low through the end sample, EVAL and the programmed delay
    task automatic wait_sort_rise(input string name);
        int waited;
        waited = 0;
        @(negedge adc_clk_i);
        while (!sort_trig_o) begin
            waited++;
            if (waited > SORT_DELAY_T + 8) begin
                stop_with_failure($sformatf("%s: sort trigger never went high", name));
            end
            @(negedge adc_clk_i);
        end
        if (waited != SORT_DELAY_T + 2) begin
            stop_with_failure($sformatf("FAILED %s: expected sort after %0d cycles, actual %0d",
                                        name, SORT_DELAY_T + 2, waited));
        end
    endtask

    task automatic check_result(input int r);
        if (rows[r].pos) begin
            wait_sort_rise(names[r]);
            // exactly SORT_DUR_T high cycles, then low
            for (int k = 1; k < SORT_DUR_T; k++) begin
                @(negedge adc_clk_i);
                check_bit(names[r], 1'b1, sort_trig_o);
            end
            @(negedge adc_clk_i);
            check_bit(names[r], 1'b0, sort_trig_o);
        end else begin
            for (int k = 0; k < SORT_DELAY_T + SORT_DUR_T + 4; k++) begin
                @(negedge adc_clk_i);
                check_bit(names[r], 1'b0, sort_trig_o);
            end
        end
        expect_reg(names[r], 32'(REG_POS_CNT), rows[r].pos_cnt);
        expect_reg(names[r], 32'(REG_NEG_CNT), rows[r].neg_cnt);
        expect_reg(names[r], 32'(REG_DROPLET_ID), rows[r].pos_cnt + rows[r].neg_cnt);
        expect_reg(names[r], 32'(REG_CLASS), 32'(rows[r].cls));
    endtask

    task automatic reset_mid_sort();
        write_reg(32'(REG_ENABLED), 32'd0);
        apply_droplet(0);
        wait_sort_rise("reset_mid_sort");
        repeat (3) @(posedge adc_clk_i);
        fads_reset      <= 1'b1;
        signal_stable_i <= 1'b0;
        @(posedge adc_clk_i);
        fads_reset <= 1'b0;
        @(negedge adc_clk_i);
        check_bit("reset_mid_sort", 1'b0, sort_trig_o);
        check_mask("reset_mid_sort", N_CHAN'(1), muxing_channels_o);
        check_defaults("reset_mid_sort");
    endtask

    // bands: int low 100..199, pos 200..999, high 1000+; width low 2..3, pos 4..9, high 10+
    task automatic load_table();
        names = '{"pos_single", "low_peak", "high_peak", "short_width", "long_width",
                  "dual_pos", "dual_ch1_low", "dual_ch1_quiet"};
        rows[0] = '{14'sd500,  14'sd0,   8'd6,  6'b00, 1'b1, 32'd1, 32'd0, 8'h92};
        rows[1] = '{14'sd150,  14'sd0,   8'd6,  6'b00, 1'b0, 32'd1, 32'd1, 8'h11};
        rows[2] = '{14'sd1500, 14'sd0,   8'd6,  6'b00, 1'b0, 32'd1, 32'd2, 8'h14};
        rows[3] = '{14'sd500,  14'sd0,   8'd3,  6'b00, 1'b0, 32'd1, 32'd3, 8'h0a};
        rows[4] = '{14'sd500,  14'sd0,   8'd12, 6'b00, 1'b0, 32'd1, 32'd4, 8'h22};
        // channel 1 in band, low, then never over its minimum
        rows[5] = '{14'sd500,  14'sd300, 8'd6,  6'b10, 1'b1, 32'd2, 32'd4, 8'h92};
        rows[6] = '{14'sd500,  14'sd150, 8'd6,  6'b10, 1'b0, 32'd2, 32'd5, 8'h13};
        rows[7] = '{14'sd500,  14'sd50,  8'd6,  6'b10, 1'b0, 32'd2, 32'd6, 8'h12};
    endtask

    // pulse, gap, delay and duration per droplet, plus bus traffic and margin
    function automatic int run_limit();
        int total;
        total = 10 + N_BUS * 4 + 200;
        for (int r = 0; r < N_ROWS; r++) begin
            total += 2 * rows[r].n + 2 + GAP + SORT_DELAY_T + SORT_DUR_T + 8;
        end
        // droplet of the mid-sort reset
        total += 2 * rows[0].n + 2 + GAP + SORT_DELAY_T + 8;
        return total;
    endfunction

    initial begin
        seed_val = $urandom(32'h04f6f7fb);
        load_table();
        cycles          = 0;
        cycle_limit     = run_limit();
        fads_reset      = 1'b1;
        adc_a_i         = '0;
        mux_addr_i      = '0;
        signal_stable_i = 1'b0;
        sys_addr_i      = '0;
        sys_wdata_i     = '0;
        sys_wen_i       = 1'b0;
        sys_ren_i       = 1'b0;
        repeat (10) @(posedge adc_clk_i);
        fads_reset <= 1'b0;
        @(posedge adc_clk_i);
        check_defaults("reset_defaults");
        check_readback();
        for (int r = 0; r < N_ROWS; r++) begin
            write_reg(32'(REG_ENABLED), 32'(rows[r].en));
            apply_droplet(r);
            check_result(r);
        end
        reset_mid_sort();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== fads_sorter.f ====
src/fads_pkg.sv
src/fads_channel.sv
src/fads_regs.sv
src/fads_sequencer.sv
src/fads_verdict.sv
src/fads_top.sv
tb/fads_tb.sv
